// ==== hdl/convPkg.sv ====
`default_nettype none

package convPkg;

    localparam int laneCount = 3;                  // Pairs per row and rows per window

    typedef logic signed [15:0] sample_t;          // One FIFO word
    typedef logic signed [31:0] product_t;         // One lane product
    typedef logic signed [33:0] rowSum_t;          // Three products added
    typedef logic signed [35:0] convSum_t;         // Three row sums added

    // One row as sent from the controller to the MAC array
    typedef struct packed {
        sample_t [laneCount-1:0] samples;          // Data samples per lane
        sample_t [laneCount-1:0] coeffs;           // Matching coefficients
    } rowWord_t;

    typedef enum logic [1:0] {
        readSample,                                // Fetch sample of current pair
        readCoeff,                                 // Fetch its coefficient
        issueRow,                                  // Last word lands this cycle
        waitFree                                   // Hold row until result stage frees
    } ctrlState_t;

endpackage

`default_nettype wire

// ==== hdl/asyncFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module asyncFifo #(
    parameter int fifoAddrWidth = 4
) (
    input  logic             wrClk,
    input  logic             wrEn,
    input  convPkg::sample_t dataIn,
    output logic             full,
    input  logic             Clk,
    input  logic             rstN,
    input  logic             rdEn,
    output convPkg::sample_t rdData,
    output logic             empty
);

    localparam int depth = 2 ** fifoAddrWidth;

    typedef logic [fifoAddrWidth:0] ptr_t;         // Extra MSB tells wrap

    convPkg::sample_t mem [depth];                 // Storage array

    ptr_t wrBin, wrBinNext;                        // Write side pointers
    ptr_t wrGray, wrGrayNext;
    ptr_t rdBin, rdBinNext;                        // Read side pointers
    ptr_t rdGray, rdGrayNext;
    ptr_t rdGraySync1, rdGraySync2;                // Read pointer in wrClk domain
    ptr_t wrGraySync1, wrGraySync2;                // Write pointer in Clk domain
    ptr_t fullMatch;                               // Gray value meaning full
    logic wrInc;
    logic rdInc;

    assign wrInc      = wrEn & ~full;              // Writes while full are dropped
    assign wrBinNext  = wrBin + ptr_t'(wrInc);
    assign wrGrayNext = (wrBinNext >> 1) ^ wrBinNext;

    assign rdInc      = rdEn & ~empty;             // Guard against underflow
    assign rdBinNext  = rdBin + ptr_t'(rdInc);
    assign rdGrayNext = (rdBinNext >> 1) ^ rdBinNext;

    // Full when write is one lap ahead of read
    assign fullMatch = {~rdGraySync2[fifoAddrWidth -: 2], rdGraySync2[fifoAddrWidth-2:0]};

    always_ff @(posedge wrClk) begin
        if (wrInc) begin
            mem[wrBin[fifoAddrWidth-1:0]] <= dataIn; // Store word
        end
    end

    always_ff @(posedge wrClk or negedge rstN) begin
        if (!rstN) begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
            full        <= 1'b0;
        end else begin
            wrBin       <= wrBinNext;
            wrGray      <= wrGrayNext;
            rdGraySync1 <= rdGray;                 // First sync flop
            rdGraySync2 <= rdGraySync1;            // Second sync flop
            full        <= (wrGrayNext == fullMatch);
        end
    end

    always_ff @(posedge Clk) begin
        if (rdInc) begin
            rdData <= mem[rdBin[fifoAddrWidth-1:0]]; // Valid next cycle
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            empty       <= 1'b1;
        end else begin
            rdBin       <= rdBinNext;
            rdGray      <= rdGrayNext;
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            empty       <= (rdGrayNext == wrGraySync2); // Pointers equal means empty
        end
    end

endmodule

`default_nettype wire

// ==== hdl/convController.sv ====
`timescale 1ns/1ps
`default_nettype none

module convController (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              empty,
    output logic              rdEn,
    input  convPkg::sample_t  rdData,
    input  logic              outFree,
    output logic              rowValid,
    output convPkg::rowWord_t row
);

    localparam int laneBits = $clog2(convPkg::laneCount);
    localparam logic [laneBits-1:0] lastIdx = laneBits'(convPkg::laneCount - 1);

    convPkg::ctrlState_t state;
    logic [laneBits-1:0] laneIdx;                  // Pair being fetched
    logic [laneBits-1:0] rowIdx;                   // Row within window
    logic [laneBits-1:0] dstLane;                  // Slot for word in flight
    logic                dstCoeff;                 // Word in flight is a coefficient
    logic                rdPend;                   // FIFO data lands this cycle
    logic                holding;                  // Full row is parked
    logic                issue;

    // One word per cycle while data is present
    assign rdEn = ~empty & (state == convPkg::readSample || state == convPkg::readCoeff);

    assign holding = (state == convPkg::issueRow) || (state == convPkg::waitFree);

    // First row of a window needs a free result stage
    assign issue = holding && ((rowIdx != '0) || outFree);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state    <= convPkg::readSample;
            laneIdx  <= '0;
            rowIdx   <= '0;
            dstLane  <= '0;
            dstCoeff <= 1'b0;
            rdPend   <= 1'b0;
            rowValid <= 1'b0;
        end else begin
            rdPend   <= rdEn;
            rowValid <= issue;                     // Strobe one cycle after last word
            if (rdEn) begin
                dstLane  <= laneIdx;
                dstCoeff <= (state == convPkg::readCoeff);
            end
            if (issue) begin
                rowIdx <= (rowIdx == lastIdx) ? '0 : rowIdx + 1'b1; // Wrap at window end
            end
            case (state)
                convPkg::readSample: begin
                    if (rdEn) state <= convPkg::readCoeff;
                end
                convPkg::readCoeff: begin
                    if (rdEn) begin
                        if (laneIdx == lastIdx) begin
                            laneIdx <= '0;
                            state   <= convPkg::issueRow; // Row complete after this word
                        end else begin
                            laneIdx <= laneIdx + 1'b1;
                            state   <= convPkg::readSample;
                        end
                    end
                end
                convPkg::issueRow: begin
                    state <= issue ? convPkg::readSample : convPkg::waitFree;
                end
                convPkg::waitFree: begin
                    if (issue) state <= convPkg::readSample; // Result stage freed
                end
                default: state <= convPkg::readSample;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (rdPend) begin
            if (dstCoeff) begin
                row.coeffs[dstLane] <= rdData;     // Coefficient slot
            end else begin
                row.samples[dstLane] <= rdData;    // Sample slot
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/macArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module macArray (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              rowValid,
    input  convPkg::rowWord_t row,
    output logic              sumValid,
    output convPkg::rowSum_t  rowSum
);

    convPkg::product_t prodReg [convPkg::laneCount]; // Stage one products
    logic              prodValid;                  // Stage one valid
    convPkg::rowSum_t  laneSum;                    // Adder tree result

    // Stage one valid and stage two valid
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            prodValid <= 1'b0;
            sumValid  <= 1'b0;
        end else begin
            prodValid <= rowValid;
            sumValid  <= prodValid;                // Two cycles after rowValid
        end
    end

    // Three multipliers in parallel
    always_ff @(posedge Clk) begin
        for (int i = 0; i < convPkg::laneCount; i++) begin
            prodReg[i] <= convPkg::product_t'(row.samples[i]) * convPkg::product_t'(row.coeffs[i]);
        end
    end

    always_comb begin
        laneSum = '0;
        for (int i = 0; i < convPkg::laneCount; i++) begin
            laneSum = laneSum + convPkg::rowSum_t'(prodReg[i]); // Sign extended
        end
    end

    always_ff @(posedge Clk) begin
        rowSum <= laneSum;                         // Stage two register
    end

endmodule

`default_nettype wire

// ==== hdl/resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultStage (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              sumValid,
    input  convPkg::rowSum_t  rowSum,
    output logic              outFree,
    output logic              resultReq,
    output convPkg::convSum_t result,
    input  logic              resultAck
);

    localparam int laneBits = $clog2(convPkg::laneCount);
    localparam logic [laneBits-1:0] lastIdx = laneBits'(convPkg::laneCount - 1);

    typedef enum logic [1:0] {
        hsIdle,                                    // Nothing pending
        hsReq,                                     // Request held high
        hsAckLow                                   // Waiting for ack to drop
    } hsState_t;

    hsState_t            hsState;
    convPkg::convSum_t   acc;                      // Running window sum
    convPkg::convSum_t   total;
    logic [laneBits-1:0] rowIdx;                   // Rows seen this window
    logic                lastRow;

    assign lastRow   = sumValid && (rowIdx == lastIdx);
    assign total     = acc + convPkg::convSum_t'(rowSum);
    assign outFree   = (hsState == hsIdle);
    assign resultReq = (hsState == hsReq);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            acc     <= '0;
            rowIdx  <= '0;
            hsState <= hsIdle;
        end else begin
            if (sumValid) begin
                acc    <= lastRow ? '0 : total;    // Clear for next window
                rowIdx <= lastRow ? '0 : rowIdx + 1'b1;
            end
            case (hsState)
                hsIdle:   if (lastRow) hsState <= hsReq;
                hsReq:    if (resultAck) hsState <= hsAckLow;
                hsAckLow: if (!resultAck) hsState <= hsIdle; // Four-phase complete
                default:  hsState <= hsIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (lastRow) begin
            result <= total;                       // Stable while req is high
        end
    end

endmodule

`default_nettype wire

// ==== hdl/convTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module convTop #(
    parameter int fifoAddrWidth = 4
) (
    input  logic              wrClk,
    input  logic              wrEn,
    input  convPkg::sample_t  dataIn,
    output logic              full,
    output logic              empty,
    input  logic              Clk,
    input  logic              rstN,
    output logic              resultReq,
    output convPkg::convSum_t result,
    input  logic              resultAck
);

    logic              rdEn;                       // Controller pops FIFO
    convPkg::sample_t  rdData;                     // FIFO output word
    logic              outFree;                    // Result stage can take a window
    logic              rowValid;
    convPkg::rowWord_t row;                        // Packed row to MAC array
    logic              sumValid;
    convPkg::rowSum_t  rowSum;                     // Row sum to result stage

    asyncFifo #(
        .fifoAddrWidth(fifoAddrWidth)
    ) i_asyncFifo (
        .wrClk   (wrClk),                          // External write clock
        .wrEn    (wrEn),
        .dataIn  (dataIn),
        .full    (full),
        .Clk     (Clk),
        .rstN    (rstN),
        .rdEn    (rdEn),
        .rdData  (rdData),
        .empty   (empty)
    );

    convController i_convController (
        .Clk      (Clk),
        .rstN     (rstN),
        .empty    (empty),
        .rdEn     (rdEn),
        .rdData   (rdData),
        .outFree  (outFree),                       // Stall at window start
        .rowValid (rowValid),
        .row      (row)
    );

    macArray i_macArray (
        .Clk      (Clk),
        .rstN     (rstN),
        .rowValid (rowValid),
        .row      (row),
        .sumValid (sumValid),
        .rowSum   (rowSum)
    );

    resultStage i_resultStage (
        .Clk       (Clk),
        .rstN      (rstN),
        .sumValid  (sumValid),
        .rowSum    (rowSum),
        .outFree   (outFree),
        .resultReq (resultReq),                    // Four-phase output
        .result    (result),
        .resultAck (resultAck)
    );

endmodule

`default_nettype wire

// ==== dv/convTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module convTb;

    localparam int fifoAddrWidth = 4;
    localparam int windowWords   = 2 * convPkg::laneCount * convPkg::laneCount; // 18 words
    localparam int numTable      = 5;
    localparam int numRandom     = 20;
    localparam int bpStart       = 4 * windowWords;  // First word of the long-ack window
    localparam int bpLimit       = 2 * windowWords + 2 ** fifoAddrWidth;
    localparam int waitLimit     = 3000;             // Cycles allowed per wait
    localparam int ackHold       = 30;               // Cycles ack stays high after req falls

    // Each row is one window, sample then coefficient for every pair
    localparam int tblWords [numTable][windowWords] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{1, 2, -3, 4, 5, -6, -7, -8, 9, 10, 100, -100, -1, 1, 2, 3, -4, -5},
        '{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768,
          -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
        '{32767, -32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767,
          -32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767, -32768},
        '{1, 1, 2, 2, 3, 3, 4, 4, 5, 5, 6, 6, 7, 7, 8, 8, 9, 9}
    };
    localparam int     tblDelay [numTable] = '{0, 3, 1, 5, 300}; // Last one holds ack
    localparam longint tblSum [numTable]   = '{64'sd0, -64'sd9869, 64'sd9663676416,
                                               -64'sd9663381504, 64'sd285};

    typedef struct packed {
        convPkg::convSum_t sum;                      // Expected window result
        int                ackDelay;                 // Cycles before ack
    } expect_t;

    logic              Clk, wrClk, rstN, wrEn, resultAck;
    logic              full, empty, resultReq;
    convPkg::sample_t  dataIn;
    convPkg::convSum_t result;
    convPkg::sample_t  streamQ [$];                  // Every word the writer pushes
    expect_t           expQ [$];                     // Results in window order
    logic [31:0]       lfsrState;

    convTop #(
        .fifoAddrWidth(fifoAddrWidth)
    ) i_convTop (
        .wrClk(wrClk), .wrEn(wrEn), .dataIn(dataIn), .full(full), .empty(empty),
        .Clk(Clk), .rstN(rstN), .resultReq(resultReq), .result(result), .resultAck(resultAck)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;                       // 10 ns core clock
    end

    initial begin
        wrClk = 1'b0;
        forever #7 wrClk = ~wrClk;                   // 14 ns write clock
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkSum(input string name, input convPkg::convSum_t expVal,
                            input convPkg::convSum_t actVal);
        if (actVal !== expVal) begin
            reportFailure($sformatf("ERR time %0t %s expected %0d actual %0d",
                                    $time, name, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            reportFailure($sformatf("ERR time %0t %s expected %b actual %b",
                                    $time, name, expVal, actVal));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic convPkg::sample_t randomWord();
        logic [15:0] bits;
        bits = '0;
        for (int b = 0; b < 16; b++) begin
            lfsrState = lfsrStep(lfsrState);         // One step per bit
            bits      = {bits[14:0], lfsrState[0]};
        end
        return convPkg::sample_t'(bits);
    endfunction

    // Exact sum of the nine sample times coefficient products
    function automatic convPkg::convSum_t modelSum(input convPkg::sample_t win [windowWords]);
        longint acc;
        acc = 0;
        for (int p = 0; p < windowWords / 2; p++) begin
            acc += longint'(win[2*p]) * longint'(win[2*p+1]);
        end
        return convPkg::convSum_t'(acc);
    endfunction

    task automatic buildStimulus();
        convPkg::sample_t win [windowWords];
        expect_t          ex;
        for (int e = 0; e < numTable + numRandom; e++) begin
            for (int w = 0; w < windowWords; w++) begin
                win[w] = (e < numTable) ? convPkg::sample_t'(tblWords[e][w]) : randomWord();
                streamQ.push_back(win[w]);
            end
            if (e < numTable) begin
                ex.sum      = convPkg::convSum_t'(tblSum[e]);
                ex.ackDelay = tblDelay[e];
                checkSum("tableSum", ex.sum, modelSum(win)); // Hand value vs model
            end else begin
                ex.sum      = modelSum(win);
                ex.ackDelay = 0;                     // Random windows ack at once
            end
            expQ.push_back(ex);
        end
    endtask

    // One word every other wrClk so full is always fresh when wrEn rises
    task automatic writeStream();
        int   timer;
        logic fullSeen;
        fullSeen = 1'b0;
        for (int i = 0; i < streamQ.size(); i++) begin
            if (i == bpStart + bpLimit) checkFlag("full", 1'b1, fullSeen);
            timer = 0;
            @(negedge wrClk);                        // full stable here
            while (full) begin
                if (i >= bpStart) fullSeen = 1'b1;
                timer++;
                if (timer > waitLimit) reportFailure("Timeout: the FIFO stayed full");
                @(negedge wrClk);
            end
            @(posedge wrClk);
            wrEn   <= 1'b1;
            dataIn <= streamQ[i];
            @(posedge wrClk);
            wrEn   <= 1'b0;                          // Word taken on this edge
        end
    endtask

    task automatic receiveResults();
        expect_t           ex;
        convPkg::convSum_t held;
        int                timer;
        while (expQ.size() > 0) begin
            ex    = expQ.pop_front();
            timer = 0;
            @(negedge Clk);
            while (!resultReq) begin
                timer++;
                if (timer > waitLimit) reportFailure("Timeout: resultReq never rose");
                @(negedge Clk);
            end
            held = result;
            checkSum("result", ex.sum, result);
            for (int d = 0; d < ex.ackDelay; d++) begin
                @(negedge Clk);
                checkFlag("resultReq", 1'b1, resultReq); // Req held without ack
                checkSum("result", held, result);
            end
            @(posedge Clk);
            resultAck <= 1'b1;
            timer = 0;
            @(negedge Clk);
            while (resultReq) begin
                checkSum("result", held, result);
                timer++;
                if (timer > 20) reportFailure("Timeout: resultReq stayed high after ack");
                @(negedge Clk);
            end
            for (int h = 0; h < ackHold; h++) begin
                @(negedge Clk);
                checkFlag("resultReq", 1'b0, resultReq); // Ack still high here
            end
            @(posedge Clk);
            resultAck <= 1'b0;
        end
    endtask

    initial begin
        rstN        = 1'b0;
        wrEn        = 1'b0;
        dataIn      = '0;
        resultAck   = 1'b0;
        lfsrState   = 32'h6ece9345;
        buildStimulus();
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        @(negedge Clk);
        checkFlag("empty", 1'b1, empty);
        checkFlag("full", 1'b0, full);
        checkFlag("resultReq", 1'b0, resultReq);
        fork
            writeStream();
            receiveResults();
        join
        repeat (20) @(negedge Clk);                  // Drain window
        checkFlag("resultReq", 1'b0, resultReq);     // No extra window
        checkFlag("empty", 1'b1, empty);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/convPkg.sv
hdl/asyncFifo.sv
hdl/convController.sv
hdl/macArray.sv
hdl/resultStage.sv
hdl/convTop.sv
dv/convTb.sv

// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing --top-module convTb -f files.f -o convSim \
    && ./obj_dir/convSim | tee sim.log
grep -q "^Result: PASSED$" sim.log 2>/dev/null && echo "Simulation ok" \
    || { echo "Simulation not ok"; exit 1; }
